//--- lsu_pkg.sv
`default_nettype none

package lsu_pkg;

    // Two memory stages issue into the data memory path
    localparam int num_lanes = 2;

    // Owner of the request currently in flight
    typedef logic lane_id_t;

    typedef logic [31:0] word_t;  // Data word on every port
    typedef logic [3:0]  strb_t;  // Byte enables with bit n for byte n

endpackage

`default_nettype wire

//--- cache_pkg.sv
`default_nettype none

package cache_pkg;

    // One 32-bit word per line in 16 lines
    localparam int tag_bits    = 26;
    localparam int index_bits  = 4;
    localparam int offset_bits = 2;
    localparam int num_sets    = 16;

    typedef struct packed {
        logic [tag_bits-1:0]    tag;
        logic [index_bits-1:0]  index;
        logic [offset_bits-1:0] offset;  // Byte within the word
    } cache_addr_t;

    // Whole word toward memory and fields for the lookup
    typedef union packed {
        logic [31:0] word;
        cache_addr_t fields;
    } cache_addr_u;

endpackage

`default_nettype wire

//--- cache_req_if.sv
`timescale 1ns/1ns
`default_nettype none

interface cache_req_if
    import lsu_pkg::*;
    import cache_pkg::*;
();

    logic        req;
    logic        we;     // High for a store
    cache_addr_u addr;
    word_t       wdata;
    strb_t       wstrb;
    logic        ack;    // Four-phase reply
    word_t       rdata;  // Load data valid with ack

    modport requester (
        output req, we, addr, wdata, wstrb,
        input  ack, rdata
    );

    modport responder (
        input  req, we, addr, wdata, wstrb,
        output ack, rdata
    );

endinterface

`default_nettype wire

//--- lsu_arbiter.sv
`timescale 1ns/1ns
`default_nettype none

module lsu_arbiter
    import lsu_pkg::*;
    import cache_pkg::*;
(
    input  wire logic                  clk,
    input  wire logic                  reset_i,
    input  wire logic                  flush_i,
    input  wire logic [num_lanes-1:0]  lane_req_i,
    input  wire logic [num_lanes-1:0]  lane_we_i,
    input  wire word_t [num_lanes-1:0] lane_addr_i,
    input  wire word_t [num_lanes-1:0] lane_wdata_i,
    input  wire strb_t [num_lanes-1:0] lane_wstrb_i,
    output logic [num_lanes-1:0]       lane_ack_o,
    output word_t                      lane_rdata_o,
    cache_req_if.requester             cache
);

    logic        busy_q;
    lane_id_t    owner_q;
    lane_id_t    win;
    logic        grant;
    logic        we_q;
    cache_addr_u addr_q;
    word_t       wdata_q;
    strb_t       wstrb_q;

    assign win   = !lane_req_i[0];  // Lane 0 has priority
    assign grant = !busy_q && !flush_i && (|lane_req_i);

    always_ff @(posedge clk) begin
        if (reset_i) begin
            busy_q  <= 1'b0;
            owner_q <= '0;
        end else if (grant) begin
            busy_q  <= 1'b1;
            owner_q <= win;
        end else if (busy_q && !lane_req_i[owner_q] && !cache.ack) begin
            busy_q <= 1'b0;  // Both sides back to zero
        end
    end

    // Request fields held for the whole handshake
    always_ff @(posedge clk) begin
        if (grant) begin
            we_q        <= lane_we_i[win];
            addr_q.word <= lane_addr_i[win];
            wdata_q     <= lane_wdata_i[win];
            wstrb_q     <= lane_wstrb_i[win];
        end
    end

    // The owning lane's req drives the cache req, so its drop passes straight on
    assign cache.req   = busy_q && lane_req_i[owner_q];
    assign cache.we    = we_q;
    assign cache.addr  = addr_q;
    assign cache.wdata = wdata_q;
    assign cache.wstrb = wstrb_q;

    always_comb begin
        lane_ack_o          = '0;
        lane_ack_o[owner_q] = busy_q && cache.ack;
    end

    assign lane_rdata_o = cache.rdata;  // Shared and qualified by ack

endmodule

`default_nettype wire

//--- dcache.sv
`timescale 1ns/1ns
`default_nettype none

module dcache
    import lsu_pkg::*;
    import cache_pkg::*;
(
    input  wire logic      clk,
    input  wire logic      reset_i,
    input  wire logic      mem_ack_i,
    input  wire word_t     mem_rdata_i,
    output logic           mem_req_o,
    output logic           mem_we_o,
    output word_t          mem_addr_o,
    output word_t          mem_wdata_o,
    output strb_t          mem_wstrb_o,
    cache_req_if.responder cpu
);

    typedef enum logic [2:0] {
        st_idle,
        st_lookup,
        st_mem,      // Memory req high until ack
        st_mem_end,  // Waiting for memory ack to fall
        st_reply
    } state_t;

    state_t state;

    logic [num_sets-1:0]    valid_q;
    logic [tag_bits-1:0]    tag_q [num_sets];
    word_t                  data_q [num_sets];

    logic [index_bits-1:0]  idx;
    logic [tag_bits-1:0]    tag;
    logic                   hit;
    logic                   refill_en;
    logic                   store_upd_en;
    logic                   ack_q;
    word_t                  rdata_q;

    // Store bytes laid over the old line word
    function automatic word_t merge_bytes(word_t old_w, word_t new_w, strb_t strb);
        word_t res;
        res = old_w;
        for (int b = 0; b < 4; b++) begin
            if (strb[b]) begin
                res[8*b +: 8] = new_w[8*b +: 8];
            end
        end
        return res;
    endfunction

    assign idx = cpu.addr.fields.index;
    assign tag = cpu.addr.fields.tag;
    assign hit = valid_q[idx] && (tag_q[idx] == tag);

    // Address is stable for the whole transaction, so hit stays valid here
    assign refill_en    = (state == st_mem) && mem_ack_i && !cpu.we;
    assign store_upd_en = (state == st_mem) && mem_ack_i && cpu.we && hit;

    always_ff @(posedge clk) begin
        if (reset_i) begin
            state     <= st_idle;
            ack_q     <= 1'b0;
            mem_req_o <= 1'b0;
        end else begin
            case (state)
                st_idle: begin
                    if (cpu.req) begin
                        state <= st_lookup;
                    end
                end
                st_lookup: begin
                    if (hit && !cpu.we) begin
                        ack_q <= 1'b1;  // Load hit needs no memory traffic
                        state <= st_reply;
                    end else begin
                        mem_req_o <= 1'b1;  // Miss refill or store-through
                        state     <= st_mem;
                    end
                end
                st_mem: begin
                    if (mem_ack_i) begin
                        mem_req_o <= 1'b0;
                        state     <= st_mem_end;
                    end
                end
                st_mem_end: begin
                    if (!mem_ack_i) begin
                        ack_q <= 1'b1;
                        state <= st_reply;
                    end
                end
                st_reply: begin
                    if (!cpu.req) begin
                        ack_q <= 1'b0;
                        state <= st_idle;
                    end
                end
                default: state <= st_idle;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (reset_i) begin
            valid_q <= '0;
        end else if (refill_en) begin
            valid_q[idx] <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (refill_en) begin
            tag_q[idx]  <= tag;
            data_q[idx] <= mem_rdata_i;
        end else if (store_upd_en) begin
            data_q[idx] <= merge_bytes(data_q[idx], cpu.wdata, cpu.wstrb);
        end
    end

    // Memory fields captured once and held while mem_req_o is high
    always_ff @(posedge clk) begin
        if (state == st_lookup) begin
            mem_we_o    <= cpu.we;
            mem_addr_o  <= cpu.addr.word;
            mem_wdata_o <= cpu.wdata;
            mem_wstrb_o <= cpu.we ? cpu.wstrb : '0;
        end
    end

    always_ff @(posedge clk) begin
        if (state == st_lookup && hit && !cpu.we) begin
            rdata_q <= data_q[idx];
        end else if (state == st_mem && mem_ack_i) begin
            rdata_q <= mem_rdata_i;  // Refill word on a load
        end
    end

    assign cpu.ack   = ack_q;
    assign cpu.rdata = rdata_q;

endmodule

`default_nettype wire

//--- lsu_top.sv
`timescale 1ns/1ns
`default_nettype none

module lsu_top
    import lsu_pkg::*;
(
    input  wire logic  clk,
    input  wire logic  reset_i,
    input  wire logic  flush_i,

    // Lane 0 from the first memory stage
    input  wire logic  lane0_req_i,
    input  wire logic  lane0_we_i,
    input  wire word_t lane0_addr_i,
    input  wire word_t lane0_wdata_i,
    input  wire strb_t lane0_wstrb_i,
    output logic       lane0_ack_o,
    output word_t      lane0_rdata_o,

    // Lane 1 from the second memory stage
    input  wire logic  lane1_req_i,
    input  wire logic  lane1_we_i,
    input  wire word_t lane1_addr_i,
    input  wire word_t lane1_wdata_i,
    input  wire strb_t lane1_wstrb_i,
    output logic       lane1_ack_o,
    output word_t      lane1_rdata_o,

    // Memory port
    output logic       mem_req_o,
    output logic       mem_we_o,
    output word_t      mem_addr_o,
    output word_t      mem_wdata_o,
    output strb_t      mem_wstrb_o,
    input  wire logic  mem_ack_i,
    input  wire word_t mem_rdata_i
);

    logic [num_lanes-1:0] lane_ack;
    word_t                lane_rdata;

    cache_req_if cache_bus ();

    lsu_arbiter arbiter0 (
        .clk          (clk),
        .reset_i      (reset_i),
        .flush_i      (flush_i),
        .lane_req_i   ({lane1_req_i, lane0_req_i}),
        .lane_we_i    ({lane1_we_i, lane0_we_i}),
        .lane_addr_i  ({lane1_addr_i, lane0_addr_i}),
        .lane_wdata_i ({lane1_wdata_i, lane0_wdata_i}),
        .lane_wstrb_i ({lane1_wstrb_i, lane0_wstrb_i}),
        .lane_ack_o   (lane_ack),
        .lane_rdata_o (lane_rdata),
        .cache        (cache_bus.requester)
    );

    dcache dcache0 (
        .clk         (clk),
        .reset_i     (reset_i),
        .mem_ack_i   (mem_ack_i),
        .mem_rdata_i (mem_rdata_i),
        .mem_req_o   (mem_req_o),
        .mem_we_o    (mem_we_o),
        .mem_addr_o  (mem_addr_o),
        .mem_wdata_o (mem_wdata_o),
        .mem_wstrb_o (mem_wstrb_o),
        .cpu         (cache_bus.responder)
    );

    assign lane0_ack_o   = lane_ack[0];
    assign lane1_ack_o   = lane_ack[1];
    assign lane0_rdata_o = lane_rdata;  // One read bus for both lanes
    assign lane1_rdata_o = lane_rdata;

endmodule

`default_nettype wire

//--- lsu_top_assertions.sv
`timescale 1ns/1ns
`default_nettype none

module lsu_top_assertions
    import lsu_pkg::*;
(
    input wire logic  clk,
    input wire logic  reset_i,
    input wire logic  lane0_req_i,
    input wire logic  lane1_req_i,
    input wire logic  lane0_ack_o,
    input wire logic  lane1_ack_o,
    input wire logic  mem_req_o,
    input wire logic  mem_we_o,
    input wire word_t mem_addr_o,
    input wire word_t mem_wdata_o,
    input wire strb_t mem_wstrb_o
);

    // Memory fields frozen during the request phase
    mem_fields_stable: assert property (@(posedge clk) disable iff (reset_i)
        (mem_req_o && $past(mem_req_o)) |-> ($stable(mem_we_o) && $stable(mem_addr_o)
            && $stable(mem_wdata_o) && $stable(mem_wstrb_o)))
        else $error("memory fields changed while mem_req_o was high");

    // Ack may outlive req by one cycle only
    lane0_ack_has_req: assert property (@(posedge clk) disable iff (reset_i)
        lane0_ack_o |-> (lane0_req_i || $past(lane0_req_i)))
        else $error("lane 0 ack without a request");

    lane1_ack_has_req: assert property (@(posedge clk) disable iff (reset_i)
        lane1_ack_o |-> (lane1_req_i || $past(lane1_req_i)))
        else $error("lane 1 ack without a request");

    acks_exclusive: assert property (@(posedge clk) disable iff (reset_i)
        !(lane0_ack_o && lane1_ack_o))
        else $error("both lane acks high together");

endmodule

bind lsu_top lsu_top_assertions chk0 (.*);

`default_nettype wire

//--- lsu_top_tb.sv
`timescale 1ns/1ns
`default_nettype none

module lsu_top_tb
    import lsu_pkg::*;
();

    logic        clk;
    logic        reset_i;
    logic        flush_i;
    logic        l_req [2];
    logic        l_we [2];
    word_t       l_addr [2];
    word_t       l_wdata [2];
    strb_t       l_wstrb [2];
    wire  [1:0]  l_ack;
    word_t       l_rdata [2];
    logic        mem_req_o;
    logic        mem_we_o;
    word_t       mem_addr_o;
    word_t       mem_wdata_o;
    strb_t       mem_wstrb_o;
    logic        mem_ack_i;
    word_t       mem_rdata_i;
    logic        lane0_ack;
    logic        lane1_ack;

    word_t       mem_model [256];
    word_t       shadow [256];
    int unsigned mem_delay;
    int          mem_req_cnt;
    int          mem_wr_cnt;
    logic        mem_req_prev;
    logic [1:0]  ack_prev;
    time         ack_time [2];
    int          errors;
    string       cur_test;

    lsu_top dut0 (
        .clk(clk), .reset_i(reset_i), .flush_i(flush_i),
        .lane0_req_i(l_req[0]), .lane0_we_i(l_we[0]), .lane0_addr_i(l_addr[0]),
        .lane0_wdata_i(l_wdata[0]), .lane0_wstrb_i(l_wstrb[0]),
        .lane0_ack_o(lane0_ack), .lane0_rdata_o(l_rdata[0]),
        .lane1_req_i(l_req[1]), .lane1_we_i(l_we[1]), .lane1_addr_i(l_addr[1]),
        .lane1_wdata_i(l_wdata[1]), .lane1_wstrb_i(l_wstrb[1]),
        .lane1_ack_o(lane1_ack), .lane1_rdata_o(l_rdata[1]),
        .mem_req_o(mem_req_o), .mem_we_o(mem_we_o), .mem_addr_o(mem_addr_o),
        .mem_wdata_o(mem_wdata_o), .mem_wstrb_o(mem_wstrb_o),
        .mem_ack_i(mem_ack_i), .mem_rdata_i(mem_rdata_i)
    );

    assign l_ack = {lane1_ack, lane0_ack};

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // Initial contents differ for every word address
    function automatic word_t fill_word(word_t a);
        return (a * 32'h9e3779b1) ^ 32'h5a5a0000 ^ a;
    endfunction

    // Expected word after the access with byte merge for a store
    function automatic word_t ref_access(word_t old_w, logic we, word_t wdata, strb_t strb);
        word_t r;
        r = old_w;
        if (we) begin
            for (int b = 0; b < 4; b++) begin
                if (strb[b]) r[8*b +: 8] = wdata[8*b +: 8];
            end
        end
        return r;
    endfunction

    // Four-phase memory with a random answer delay
    always @(posedge clk) begin
        if (reset_i) begin
            mem_ack_i <= 1'b0;
            mem_delay <= 0;
        end else if (mem_req_o && !mem_ack_i) begin
            if (mem_delay == 0) begin
                mem_ack_i <= 1'b1;
                mem_delay <= $urandom % 4;
                if (mem_we_o) begin
                    for (int b = 0; b < 4; b++) begin
                        if (mem_wstrb_o[b]) begin
                            mem_model[mem_addr_o[9:2]][8*b +: 8] <= mem_wdata_o[8*b +: 8];
                        end
                    end
                end else begin
                    mem_rdata_i <= mem_model[mem_addr_o[9:2]];
                end
            end else begin
                mem_delay <= mem_delay - 1;
            end
        end else if (!mem_req_o && mem_ack_i) begin
            mem_ack_i <= 1'b0;
        end
    end

    // Memory request counter counting rising req edges
    always @(posedge clk) begin
        if (mem_req_o && !mem_req_prev) begin
            mem_req_cnt <= mem_req_cnt + 1;
            if (mem_we_o) mem_wr_cnt <= mem_wr_cnt + 1;
        end
        mem_req_prev <= mem_req_o;
    end

    // Compare every lane ack in service order
    always @(posedge clk) begin
        word_t exp_w;
        for (int l = 0; l < 2; l++) begin
            if (l_ack[l] && !ack_prev[l]) begin
                ack_time[l] = $time;
                exp_w = ref_access(shadow[l_addr[l][9:2]], l_we[l], l_wdata[l], l_wstrb[l]);
                if (l_we[l]) begin
                    if (mem_model[l_addr[l][9:2]] != exp_w) begin
                        $display("[ERROR] %s: store lane %0d expected %h, actual %h",
                                 cur_test, l, exp_w, mem_model[l_addr[l][9:2]]);
                        errors++;
                    end
                    shadow[l_addr[l][9:2]] = exp_w;
                end else if (l_rdata[l] != exp_w) begin
                    $display("[ERROR] %s: load lane %0d expected %h, actual %h",
                             cur_test, l, exp_w, l_rdata[l]);
                    errors++;
                end
            end
        end
        ack_prev <= l_ack;
    end

    // One full four-phase cycle on a lane
    task automatic lane_op(input int lane, input logic we, input word_t addr,
                           input word_t wdata, input strb_t strb);
        int n;
        @(posedge clk);
        l_req[lane]   <= 1'b1;
        l_we[lane]    <= we;
        l_addr[lane]  <= addr;
        l_wdata[lane] <= wdata;
        l_wstrb[lane] <= strb;
        n = 0;
        @(posedge clk);
        while (!l_ack[lane] && n < 400) begin
            @(posedge clk);
            n++;
        end
        if (!l_ack[lane]) begin
            $display("%s: lane %0d got no ack in time", cur_test, lane);
            errors++;
        end
        l_req[lane] <= 1'b0;
        n = 0;
        while (l_ack[lane] && n < 50) begin
            @(posedge clk);
            n++;
        end
        if (l_ack[lane]) begin
            $display("%s: lane %0d ack did not fall", cur_test, lane);
            errors++;
        end
    endtask

    task automatic check_count(input string what, input int exp_n, input int act_n);
        if (exp_n != act_n) begin
            $display("[ERROR] %s %s: expected %0d, actual %0d", cur_test, what, exp_n, act_n);
            errors++;
        end
    endtask

    initial begin
        int c0;
        int w0;
        void'($urandom(32'hcf14));
        errors = 0;
        mem_req_cnt = 0;
        mem_wr_cnt = 0;
        mem_req_prev = 1'b0;
        ack_prev = '0;
        mem_rdata_i = '0;
        mem_ack_i = 1'b0;
        flush_i = 1'b0;
        for (int i = 0; i < 256; i++) begin
            mem_model[i] = fill_word(word_t'(i) << 2);
            shadow[i]    = fill_word(word_t'(i) << 2);
        end
        for (int l = 0; l < 2; l++) begin
            l_req[l] = 1'b0;
            l_we[l] = 1'b0;
            l_addr[l] = '0;
            l_wdata[l] = '0;
            l_wstrb[l] = '0;
        end
        reset_i = 1'b1;
        repeat (8) @(posedge clk);
        reset_i <= 1'b0;

        cur_test = "idle_after_reset";
        repeat (10) begin
            @(posedge clk);
            if (l_ack != 2'b00 || mem_req_o) begin
                $display("%s: ack or memory request seen without any lane request", cur_test);
                errors++;
            end
        end

        cur_test = "store_then_load";
        w0 = mem_wr_cnt;
        c0 = mem_req_cnt;
        lane_op(0, 1'b1, 32'h10, 32'hdeadbeef, 4'b0101);
        check_count("memory writes", 1, mem_wr_cnt - w0);
        check_count("memory requests", 1, mem_req_cnt - c0);
        lane_op(0, 1'b0, 32'h10, '0, '0);

        cur_test = "hit_and_conflict";
        c0 = mem_req_cnt;
        lane_op(0, 1'b0, 32'h10, '0, '0);
        check_count("hit requests", 0, mem_req_cnt - c0);
        c0 = mem_req_cnt;
        lane_op(1, 1'b0, 32'h50, '0, '0);  // Same index with another tag
        check_count("miss requests", 1, mem_req_cnt - c0);
        c0 = mem_req_cnt;
        lane_op(1, 1'b0, 32'h50, '0, '0);
        check_count("rehit requests", 0, mem_req_cnt - c0);

        cur_test = "both_lanes";
        fork
            lane_op(0, 1'b0, 32'h20, '0, '0);
            lane_op(1, 1'b1, 32'h24, 32'h12345678, 4'b1111);
        join
        if (ack_time[0] >= ack_time[1]) begin
            $display("%s: lane 0 was not served before lane 1", cur_test);
            errors++;
        end

        cur_test = "flush_hold";
        @(posedge clk);
        flush_i <= 1'b1;
        c0 = mem_req_cnt;
        fork
            lane_op(0, 1'b0, 32'h30, '0, '0);
            begin
                repeat (20) begin
                    @(posedge clk);
                    if (l_ack[0] || mem_req_o) begin
                        $display("%s: request served while flush_i was high", cur_test);
                        errors++;
                    end
                end
                flush_i <= 1'b0;
            end
        join
        check_count("requests after flush", 1, mem_req_cnt - c0);

        cur_test = "random_mix";
        for (int i = 0; i < 150; i++) begin
            fork
                lane_op(0, 1'($urandom % 2), ($urandom % 64) << 2, $urandom, 4'($urandom));
                lane_op(1, 1'($urandom % 2), ($urandom % 64) << 2, $urandom, 4'($urandom));
            join
        end

        repeat (4) @(posedge clk);
        $display("Error count: %0d", errors);
        if (errors == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

    // Whole-run limit
    initial begin
        repeat (200000) @(posedge clk);
        $display("Run stopped by the overall time limit");
        $display("Errors found");
        $finish;
    end

endmodule

`default_nettype wire

//--- lsu_top.f
lsu_pkg.sv
cache_pkg.sv
cache_req_if.sv
lsu_arbiter.sv
dcache.sv
lsu_top.sv
lsu_top_assertions.sv
lsu_top_tb.sv

//--- run_sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert --top-module lsu_top_tb -f lsu_top.f -o lsu_sim
./obj_dir/lsu_sim | tee sim.log

# The log decides pass or fail
grep -q "No errors" sim.log
